// ==== aud_capture_top.f ====
rtl/aud_pkg.sv
rtl/aud_rec_ctrl.sv
rtl/aud_channel_deser.sv
rtl/aud_sample_fifo.sv
rtl/aud_frame_writer.sv
rtl/aud_capture_top.sv
test/aud_capture_props.sv
test/aud_capture_tb.sv

// ==== rtl/aud_capture_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module aud_capture_top #(
    parameter int MAX_WORDS   = 1024000,
    parameter int FIFO_DEPTH  = 4,
    parameter int MAX_CREDITS = 4,
    parameter bit LEFT_LRC    = 1'b0
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_lrc,
    input  logic             i_data,
    input  logic             i_start,
    input  logic             i_pause,
    input  logic             i_stop,
    input  logic             i_credit,
    output aud_pkg::mem_wr_t o_wr,
    output logic             o_finish,
    output aud_pkg::status_t o_status
);

    aud_pkg::sample_t left_sample, right_sample;
    aud_pkg::sample_t left_head, right_head;
    logic left_valid, right_valid;
    logic left_empty, right_empty;
    logic left_full, right_full;
    logic left_pop, right_pop;
    logic capture_en, limit, recording, paused, overrun;

    assign o_status = '{recording: recording, paused: paused, overrun: overrun};

    aud_rec_ctrl aud_rec_ctrl_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_pause      (i_pause),
        .i_stop       (i_stop),
        .i_limit      (limit),
        .o_capture_en (capture_en),
        .o_finish     (o_finish),
        .o_recording  (recording),
        .o_paused     (paused)
    );

    // ##################################################################
    // Left and right capture paths
    // ##################################################################

    aud_channel_deser #(.LEFT_LRC(LEFT_LRC)) left_deser_i (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_lrc (i_lrc), .i_data (i_data),
        .i_capture_en (capture_en), .o_sample (left_sample), .o_sample_valid (left_valid)
    );

    aud_channel_deser #(.LEFT_LRC(!LEFT_LRC)) right_deser_i (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_lrc (i_lrc), .i_data (i_data),
        .i_capture_en (capture_en), .o_sample (right_sample), .o_sample_valid (right_valid)
    );

    aud_sample_fifo #(.DEPTH(FIFO_DEPTH)) left_fifo_i (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_push (left_valid), .i_din (left_sample),
        .i_pop (left_pop), .o_dout (left_head), .o_empty (left_empty), .o_full (left_full)
    );

    aud_sample_fifo #(.DEPTH(FIFO_DEPTH)) right_fifo_i (
        .i_clk (i_clk), .i_rst_n (i_rst_n), .i_push (right_valid), .i_din (right_sample),
        .i_pop (right_pop), .o_dout (right_head), .o_empty (right_empty), .o_full (right_full)
    );

    aud_frame_writer #(.MAX_WORDS(MAX_WORDS), .MAX_CREDITS(MAX_CREDITS)) aud_frame_writer_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_left        (left_head),
        .i_left_empty  (left_empty),
        .i_right       (right_head),
        .i_right_empty (right_empty),
        .i_left_drop   (left_valid && left_full),
        .i_right_drop  (right_valid && right_full),
        .i_credit      (i_credit),
        .o_left_pop    (left_pop),
        .o_right_pop   (right_pop),
        .o_wr          (o_wr),
        .o_limit       (limit),
        .o_overrun     (overrun)
    );

endmodule

`default_nettype wire

// ==== rtl/aud_channel_deser.sv ====
`timescale 1ns/100ps
`default_nettype none

module aud_channel_deser #(
    parameter bit LEFT_LRC = 1'b0
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_lrc,
    input  logic             i_data,
    input  logic             i_capture_en,
    output aud_pkg::sample_t o_sample,
    output logic             o_sample_valid
);

    localparam int CNT_W = $clog2(aud_pkg::SAMPLE_W + 1);

    logic                         lrc_r;
    logic [CNT_W-1:0]             counter_r, counter_w;
    logic [aud_pkg::SAMPLE_W-1:0] shift_r, shift_w;
    logic                         valid_r, valid_w;

    assign o_sample.data  = shift_r;
    assign o_sample_valid = valid_r;

    always_comb begin
        counter_w = counter_r;
        shift_w   = shift_r;
        valid_w   = 1'b0;
        // The edge that first sees lrc at our level only arms the counter,
        // the MSB follows one bit clock later as usual for I2S
        if (i_lrc == LEFT_LRC && lrc_r != LEFT_LRC) begin
            counter_w = '0;
        end
        else if (counter_r != CNT_W'(aud_pkg::SAMPLE_W)) begin
            shift_w   = {shift_r[aud_pkg::SAMPLE_W-2:0], i_data};
            counter_w = counter_r + 1'b1;
            // Capture enable gates only the pulse, the sample still completes
            valid_w   = i_capture_en && (counter_r == CNT_W'(aud_pkg::SAMPLE_W - 1));
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            lrc_r     <= i_lrc;
            counter_r <= CNT_W'(aud_pkg::SAMPLE_W);
            valid_r   <= 1'b0;
        end
        else begin
            lrc_r     <= i_lrc;
            counter_r <= counter_w;
            valid_r   <= valid_w;
        end
    end

    always_ff @(posedge i_clk) begin
        shift_r <= shift_w;
    end

endmodule

`default_nettype wire

// ==== rtl/aud_frame_writer.sv ====
`timescale 1ns/100ps
`default_nettype none

module aud_frame_writer #(
    parameter int MAX_WORDS   = 1024000,
    parameter int MAX_CREDITS = 4
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  aud_pkg::sample_t i_left,
    input  logic             i_left_empty,
    input  aud_pkg::sample_t i_right,
    input  logic             i_right_empty,
    input  logic             i_left_drop,
    input  logic             i_right_drop,
    input  logic             i_credit,
    output logic             o_left_pop,
    output logic             o_right_pop,
    output aud_pkg::mem_wr_t o_wr,
    output logic             o_limit,
    output logic             o_overrun
);

    localparam int CRED_W = $clog2(MAX_CREDITS + 1);

    logic [CRED_W-1:0]          credit_r, credit_w;
    logic [aud_pkg::ADDR_W-1:0] address_r, address_w;
    logic                       next_ch_r, next_ch_w;
    logic                       overrun_r, overrun_w;
    aud_pkg::mem_wr_t           wr_r, wr_w;
    logic                       can_issue;
    logic                       pop;

    assign o_wr      = wr_r;
    assign o_limit   = (address_r == aud_pkg::ADDR_W'(MAX_WORDS));
    assign o_overrun = overrun_r;

    // ##################################################################
    // Issue: one word per pop, left then right, under credit
    // ##################################################################

    // A write still on o_wr has not given back its credit yet
    assign can_issue   = (credit_r > CRED_W'(wr_r.valid)) && !o_limit;
    assign o_left_pop  = can_issue && !next_ch_r && !i_left_empty;
    assign o_right_pop = can_issue && next_ch_r && !i_right_empty;
    assign pop         = o_left_pop || o_right_pop;

    always_comb begin
        address_w  = address_r;
        next_ch_w  = next_ch_r;
        wr_w.valid = pop;
        wr_w.addr  = address_r;
        wr_w.data  = next_ch_r ? i_right : i_left;
        if (pop) begin
            address_w = address_r + 1'b1;
            next_ch_w = !next_ch_r;
        end
        // Each write on o_wr takes one credit, each returned pulse gives one
        credit_w  = credit_r - CRED_W'(wr_r.valid) + CRED_W'(i_credit);
        overrun_w = overrun_r || i_left_drop || i_right_drop;
    end

    // ##################################################################
    // Registers
    // ##################################################################

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            credit_r   <= CRED_W'(MAX_CREDITS);
            address_r  <= '0;
            next_ch_r  <= 1'b0;
            overrun_r  <= 1'b0;
            wr_r.valid <= 1'b0;
        end
        else begin
            credit_r   <= credit_w;
            address_r  <= address_w;
            next_ch_r  <= next_ch_w;
            overrun_r  <= overrun_w;
            wr_r.valid <= wr_w.valid;
        end
    end

    always_ff @(posedge i_clk) begin
        wr_r.addr <= wr_w.addr;
        wr_r.data <= wr_w.data;
    end

endmodule

`default_nettype wire

// ==== rtl/aud_pkg.sv ====
`default_nettype none

package aud_pkg;

    // ##################################################################
    // Widths shared by the capture path and the memory side
    // ##################################################################

    localparam int SAMPLE_W = 16;
    localparam int ADDR_W   = 20;

    // One audio sample word, one word per sample in memory
    typedef struct packed {
        logic [SAMPLE_W-1:0] data;
    } sample_t;

    // One write toward the sample memory
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        sample_t           data;
    } mem_wr_t;

    // ##################################################################
    // Recorder control
    // ##################################################################

    typedef enum logic [1:0] {
        IDLE,
        REC,
        PAUSE,
        FINISH
    } rec_state_t;

    typedef struct packed {
        logic recording;
        logic paused;
        logic overrun;
    } status_t;

endpackage

`default_nettype wire

// ==== rtl/aud_rec_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module aud_rec_ctrl (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_start,
    input  logic i_pause,
    input  logic i_stop,
    input  logic i_limit,
    output logic o_capture_en,
    output logic o_finish,
    output logic o_recording,
    output logic o_paused
);

    aud_pkg::rec_state_t state_r, state_w;
    logic start_r;

    // Samples are only accepted while actively recording
    assign o_capture_en = (state_r == aud_pkg::REC);
    assign o_finish     = (state_r == aud_pkg::FINISH);
    assign o_recording  = (state_r == aud_pkg::REC) || (state_r == aud_pkg::PAUSE);
    assign o_paused     = (state_r == aud_pkg::PAUSE);

    always_comb begin
        state_w = state_r;
        case (state_r)
            aud_pkg::IDLE: begin
                // The button starts recording when it is released
                if (!i_start && start_r) begin
                    state_w = aud_pkg::REC;
                end
            end
            aud_pkg::REC: begin
                if (i_stop || i_limit) begin
                    state_w = aud_pkg::FINISH;
                end
                else if (i_pause) begin
                    state_w = aud_pkg::PAUSE;
                end
            end
            aud_pkg::PAUSE: begin
                // Stop wins over a pause toggle in the same cycle
                if (i_stop || i_limit) begin
                    state_w = aud_pkg::FINISH;
                end
                else if (i_pause) begin
                    state_w = aud_pkg::REC;
                end
            end
            aud_pkg::FINISH: begin
                state_w = aud_pkg::IDLE;
            end
            default: begin
                state_w = aud_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            state_r <= aud_pkg::IDLE;
            start_r <= 1'b0;
        end
        else begin
            state_r <= state_w;
            start_r <= i_start;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/aud_sample_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module aud_sample_fifo #(
    parameter int DEPTH = 4
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_push,
    input  aud_pkg::sample_t i_din,
    input  logic             i_pop,
    output aud_pkg::sample_t o_dout,
    output logic             o_empty,
    output logic             o_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    aud_pkg::sample_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_r, rd_ptr_r;
    logic [CNT_W-1:0] count_r;
    logic             do_push, do_pop;

    assign o_empty = (count_r == '0);
    assign o_full  = (count_r == CNT_W'(DEPTH));
    assign o_dout  = mem[rd_ptr_r];

    // A push into a full FIFO is lost, a pop from an empty one does nothing
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem[wr_ptr_r] <= i_din;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
        end
        else begin
            if (do_push) begin
                wr_ptr_r <= (wr_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_r <= (rd_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
            end
            count_r <= count_r + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -j 0 --top-module aud_capture_tb \
    -f aud_capture_top.f -o aud_capture_sim \
    && ./obj_dir/aud_capture_sim \
    || exit 1

// ==== test/aud_capture_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module aud_capture_props #(
    parameter int MAX_CREDITS = 4,
    parameter int CRED_W      = 3
) (
    input logic                       i_clk,
    input logic                       i_rst_n,
    input logic [CRED_W-1:0]          i_credits,
    input aud_pkg::mem_wr_t           i_wr,
    input logic                       i_limit
);

    logic [aud_pkg::ADDR_W-1:0] wr_count_r;

    // Every write seen so far has used one address, so the count is the next one
    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            wr_count_r <= '0;
        end
        else if (i_wr.valid) begin
            wr_count_r <= wr_count_r + 1'b1;
        end
    end

    // A write on the bus still holds the credit it was issued with
    wr_has_credit: assert property (@(posedge i_clk) disable iff (i_rst_n)
        i_wr.valid |-> i_credits != '0)
        else $error("Write presented without a credit");

    credits_bounded: assert property (@(posedge i_clk) disable iff (i_rst_n)
        i_credits <= CRED_W'(MAX_CREDITS))
        else $error("Credit count above the maximum");

    addr_step: assert property (@(posedge i_clk) disable iff (i_rst_n)
        i_wr.valid |-> i_wr.addr == wr_count_r)
        else $error("Write address did not advance by one");

    // The last word leaves in the cycle the limit rises, none after it
    no_wr_after_limit: assert property (@(posedge i_clk) disable iff (i_rst_n)
        i_limit |=> !i_wr.valid)
        else $error("Write issued after the word limit");

endmodule

bind aud_frame_writer aud_capture_props #(
    .MAX_CREDITS (MAX_CREDITS),
    .CRED_W      (CRED_W)
) aud_capture_props_i (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_credits (credit_r),
    .i_wr      (o_wr),
    .i_limit   (o_limit)
);

`default_nettype wire

// ==== test/aud_capture_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module aud_capture_tb;

    localparam int MAX_WORDS   = 12;
    localparam int FIFO_DEPTH  = 4;
    localparam int MAX_CREDITS = 4;
    localparam int TIMEOUT     = 1000;

    logic clk;
    logic rst_n;
    logic lrc;
    logic data;
    logic start;
    logic pause;
    logic stop;
    logic credit;

    aud_pkg::mem_wr_t wr;
    logic             finish;
    aud_pkg::status_t status;

    // Reference model state
    aud_pkg::mem_wr_t exp_q[$];
    int               credit_due_q[$];
    logic             rec_m = 1'b0;
    logic             paused_m = 1'b0;
    logic             overrun_m = 1'b0;
    logic             limit_m = 1'b0;
    int               addr_m = 0;
    int               exp_finish = 0;
    int               starve_until = 0;
    int               starve_frames = 0;

    int     cycle = 0;
    int     finish_count = 0;
    logic   finish_prev = 1'b0;
    integer seed = 32'h69c0;

    aud_capture_top #(
        .MAX_WORDS   (MAX_WORDS),
        .FIFO_DEPTH  (FIFO_DEPTH),
        .MAX_CREDITS (MAX_CREDITS)
    ) aud_capture_top_i (
        .i_clk    (clk),
        .i_rst_n  (rst_n),
        .i_lrc    (lrc),
        .i_data   (data),
        .i_start  (start),
        .i_pause  (pause),
        .i_stop   (stop),
        .i_credit (credit),
        .o_wr     (wr),
        .o_finish (finish),
        .o_status (status)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // ######################################################################
    // Error reporting and compare tasks
    // ######################################################################

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_wr(input string name, input aud_pkg::mem_wr_t exp,
                            input aud_pkg::mem_wr_t got);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL %s expected %h got %h", name, exp, got));
        end
    endtask

    task automatic check_status(input string name, input aud_pkg::status_t exp,
                                input aud_pkg::status_t got);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL %s expected %h got %h", name, exp, got));
        end
    endtask

    task automatic check_finish(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL %s expected %h got %h", name, exp, got));
        end
    endtask

    function automatic aud_pkg::status_t model_status();
        aud_pkg::status_t s;
        s.recording = rec_m;
        s.paused    = paused_m;
        s.overrun   = overrun_m;
        return s;
    endfunction

    function automatic int credit_delay();
        return 1 + int'($unsigned($random(seed)) % 32'd4);
    endfunction

    // ######################################################################
    // Memory side: write monitor and credit return
    // ######################################################################

    always @(negedge clk) begin
        if (!rst_n) begin
            if (wr.valid) begin
                if (exp_q.size() == 0) begin
                    stop_on_error("A write appeared on o_wr while none was expected");
                end
                check_wr("o_wr", exp_q[0], wr);
                exp_q.delete(0);
                credit_due_q.push_back(cycle + credit_delay());
            end
            // The finish pulse lasts exactly one cycle
            if (finish_prev) begin
                check_finish("o_finish", 1'b0, finish);
            end
            if (finish) begin
                finish_count++;
            end
            finish_prev = finish;
        end
    end

    initial begin
        credit = 1'b0;
        forever begin
            @(posedge clk);
            #10;
            if (credit_due_q.size() > 0 && credit_due_q[0] <= cycle && cycle >= starve_until) begin
                credit = 1'b1;
                credit_due_q.delete(0);
            end
            else begin
                credit = 1'b0;
            end
        end
    end

    // ######################################################################
    // Stimulus and reference model
    // ######################################################################

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic expect_word(input logic [aud_pkg::SAMPLE_W-1:0] word);
        aud_pkg::mem_wr_t w;
        w.valid     = 1'b1;
        w.addr      = aud_pkg::ADDR_W'(addr_m);
        w.data.data = word;
        if (addr_m < MAX_WORDS) begin
            exp_q.push_back(w);
        end
        addr_m++;
        if (addr_m == MAX_WORDS) begin
            limit_m = 1'b1;
        end
    endtask

    task automatic model_frame(input logic [aud_pkg::SAMPLE_W-1:0] left,
                               input logic [aud_pkg::SAMPLE_W-1:0] right);
        logic dropped;
        dropped = 1'b0;
        if (rec_m && !paused_m) begin
            // Without credits only the in-flight words and the FIFOs hold frames
            if (cycle < starve_until) begin
                if (starve_frames >= MAX_CREDITS / 2 + FIFO_DEPTH) begin
                    dropped   = 1'b1;
                    overrun_m = 1'b1;
                end
                else begin
                    starve_frames++;
                end
            end
            if (!dropped) begin
                expect_word(left);
                expect_word(right);
            end
        end
    endtask

    task automatic send_channel(input logic level, input logic [aud_pkg::SAMPLE_W-1:0] word);
        next_cycle();
        lrc  = level;
        data = 1'b0;
        for (int i = aud_pkg::SAMPLE_W - 1; i >= 0; i--) begin
            next_cycle();
            data = word[i];
        end
    endtask

    task automatic wait_writes_done();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            if (n == TIMEOUT) begin
                stop_on_error("Timed out waiting for the expected memory writes");
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic wait_credits_back();
        int n;
        n = 0;
        while (credit_due_q.size() != 0) begin
            if (n == TIMEOUT) begin
                stop_on_error("Timed out waiting for outstanding credits to return");
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic wait_starve_end();
        int n;
        n = 0;
        while (cycle < starve_until) begin
            if (n == TIMEOUT) begin
                stop_on_error("Timed out waiting for the credit starvation window to end");
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic wait_finish();
        int n;
        n = 0;
        while (finish_count != exp_finish) begin
            if (n == TIMEOUT) begin
                stop_on_error("Timed out waiting for the finish pulse");
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic press_start();
        next_cycle();
        start = 1'b1;
        @(negedge clk);
        check_status("o_status", model_status(), status);
        next_cycle();
        start = 1'b0;
        @(negedge clk);
        check_status("o_status", model_status(), status);
        rec_m    = 1'b1;
        paused_m = 1'b0;
        @(negedge clk);
        check_status("o_status", model_status(), status);
    endtask

    task automatic pulse_pause();
        next_cycle();
        pause = 1'b1;
        next_cycle();
        pause = 1'b0;
        if (rec_m) begin
            paused_m = !paused_m;
        end
        @(negedge clk);
        check_status("o_status", model_status(), status);
    endtask

    task automatic pulse_stop();
        if (rec_m) begin
            rec_m    = 1'b0;
            paused_m = 1'b0;
            exp_finish++;
        end
        next_cycle();
        stop = 1'b1;
        next_cycle();
        stop = 1'b0;
        wait_finish();
        @(negedge clk);
        check_status("o_status", model_status(), status);
    endtask

    task automatic expect_flags(input logic exp_overrun);
        wait_starve_end();
        wait_writes_done();
        if (limit_m && rec_m) begin
            rec_m    = 1'b0;
            paused_m = 1'b0;
            exp_finish++;
        end
        wait_finish();
        repeat (2) @(negedge clk);
        if (overrun_m !== exp_overrun) begin
            stop_on_error("The overrun value in the stimulus file disagrees with the model");
        end
        check_status("o_status", model_status(), status);
    endtask

    initial begin
        int                            fd;
        int                            code;
        int                            cycles;
        string                         cmd;
        string                         rest;
        logic [aud_pkg::SAMPLE_W-1:0]  left;
        logic [aud_pkg::SAMPLE_W-1:0]  right;
        logic                          exp_overrun;

        rst_n = 1'b1;
        lrc   = 1'b1;
        data  = 1'b0;
        start = 1'b0;
        pause = 1'b0;
        stop  = 1'b0;
        repeat (2) @(posedge clk);
        #10;
        rst_n = 1'b0;

        // Nothing may happen before the start button is released
        repeat (4) begin
            @(negedge clk);
            check_status("o_status", model_status(), status);
            check_finish("o_finish", 1'b0, finish);
        end

        fd = $fopen("test/aud_stim.txt", "r");
        if (fd == 0) begin
            stop_on_error("Could not open the stimulus file test/aud_stim.txt");
        end
        while ($fscanf(fd, "%s", cmd) == 1) begin
            if (cmd.substr(0, 0) == "#") begin
                code = $fgets(rest, fd);
            end
            else if (cmd == "START") begin
                press_start();
            end
            else if (cmd == "PAUSE") begin
                pulse_pause();
            end
            else if (cmd == "STOP") begin
                pulse_stop();
            end
            else if (cmd == "FRAME") begin
                code = $fscanf(fd, "%h %h", left, right);
                if (code != 2) begin
                    stop_on_error("A FRAME line in the stimulus file is malformed");
                end
                model_frame(left, right);
                send_channel(1'b0, left);
                send_channel(1'b1, right);
            end
            else if (cmd == "STARVE") begin
                code = $fscanf(fd, "%d", cycles);
                if (code != 1) begin
                    stop_on_error("A STARVE line in the stimulus file is malformed");
                end
                wait_writes_done();
                wait_credits_back();
                repeat (2) @(negedge clk);
                starve_until  = cycle + cycles;
                starve_frames = 0;
            end
            else if (cmd == "EXPECT") begin
                code = $fscanf(fd, "%h", exp_overrun);
                if (code != 1) begin
                    stop_on_error("An EXPECT line in the stimulus file is malformed");
                end
                expect_flags(exp_overrun);
            end
            else begin
                stop_on_error("The stimulus file holds an unknown command");
            end
        end
        $fclose(fd);

        wait_writes_done();
        repeat (20) @(negedge clk);
        if (exp_q.size() == 0 && finish_count == exp_finish) begin
            $display("Test passed");
            $finish;
        end
        else begin
            stop_on_error("The number of finish pulses differs from the model");
        end
    end

endmodule

`default_nettype wire

// ==== test/aud_stim.txt ====
# Columns: command then arguments. FRAME <left hex> <right hex>, STARVE <cycles>,
# EXPECT <overrun>. START, PAUSE and STOP take no arguments.
START
FRAME 1234 abcd
FRAME 8001 7ffe
PAUSE
FRAME dead beef
PAUSE
FRAME 0f0f f0f0
STOP
FRAME 5555 aaaa
EXPECT 0
# Second take: credits held back until the FIFOs overflow, then the limit ends it
START
STARVE 300
FRAME 0001 0002
FRAME 0103 0204
FRAME 1005 2006
FRAME 3007 4008
FRAME 5009 600a
FRAME 700b 800c
FRAME 900d a00e
FRAME b00f c010
EXPECT 1
